//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [7:0]  byte_t;       // One lane of the memory
    typedef logic [31:0] word_t;       // APB data width
    typedef logic [3:0]  lane_mask_t;  // One bit per byte lane
    typedef logic [1:0]  align_t;      // Byte offset inside a word

    // Size code as carried in the paddr alias window
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_BAD  = 2'd3
    } access_size_e;

    localparam int SIZE_LSB         = 12;  // paddr[13:12] is the size
    localparam int SIGN_BIT         = 14;  // paddr[14] asks for a signed load
    localparam int ADDR_FIELD_WIDTH = 12;  // Byte address part of paddr

endpackage

`default_nettype wire

//--- mem_lane_if.sv
`default_nettype none

// Per-lane path between the APB controller, the store merge and the banks
interface mem_lane_if
    import lsu_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 10
) ();

    logic                      rd_en;
    logic [MEM_ADDR_WIDTH-3:0] word_index;
    lane_mask_t                wr_en;
    byte_t                     wr_byte [4];
    byte_t                     rd_byte [4];

    modport ctrl (
        output rd_en,
        output word_index
    );

    modport merge (
        output wr_en,
        output wr_byte,
        input  rd_byte
    );

    modport load (
        input rd_byte
    );

    modport mem (
        output rd_byte,
        input  rd_en,
        input  word_index,
        input  wr_en,
        input  wr_byte
    );

endinterface

`default_nettype wire

//--- byte_bank.sv
`default_nettype none

module byte_bank
    import lsu_pkg::*;
#(
    parameter int DEPTH_WIDTH = 8
) (
    input  wire logic                   clk,
    input  wire logic [DEPTH_WIDTH-1:0] addr,
    input  wire logic                   we,
    input  wire byte_t                  wdata,
    output byte_t                       rdata
);

    byte_t mem [2**DEPTH_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- lane_memory.sv
`default_nettype none

module lane_memory #(
    parameter int MEM_ADDR_WIDTH = 10
) (
    input wire logic clk,
    input wire logic reset,
    mem_lane_if.mem  lanes
);

    localparam int DEPTH_WIDTH = MEM_ADDR_WIDTH - 2;

    logic [DEPTH_WIDTH-1:0] index_q;
    logic [DEPTH_WIDTH-1:0] bank_addr;

    // Hold the word of the setup cycle for the write in the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            index_q <= '0;
        end else if (lanes.rd_en) begin
            index_q <= lanes.word_index;
        end
    end

    // New index reads straight away, the held one serves the write
    assign bank_addr = lanes.rd_en ? lanes.word_index : index_q;

    for (genvar i = 0; i < 4; i++) begin : g_lane
        byte_bank #(
            .DEPTH_WIDTH(DEPTH_WIDTH)
        ) byte_bank_inst (
            .clk  (clk),
            .addr (bank_addr),
            .we   (lanes.wr_en[i]),
            .wdata(lanes.wr_byte[i]),
            .rdata(lanes.rd_byte[i])
        );
    end

endmodule

`default_nettype wire

//--- load_align.sv
`default_nettype none

module load_align
    import lsu_pkg::*;
(
    mem_lane_if.load          lanes,
    input  wire align_t       alignment,
    input  wire access_size_e size,
    input  wire logic         sign,
    output word_t             load_data
);

    word_t lane_word;
    word_t shifted;

    assign lane_word = {lanes.rd_byte[3], lanes.rd_byte[2], lanes.rd_byte[1], lanes.rd_byte[0]};

    // Addressed byte lands in lane 0
    assign shifted = lane_word >> {alignment, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                if (sign) begin
                    load_data = {{24{shifted[7]}}, shifted[7:0]};
                end else begin
                    load_data = {24'd0, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (sign) begin
                    load_data = {{16{shifted[15]}}, shifted[15:0]};
                end else begin
                    load_data = {16'd0, shifted[15:0]};
                end
            end
            default: begin
                load_data = shifted;  // Word, sign has no effect
            end
        endcase
    end

endmodule

`default_nettype wire

//--- store_merge.sv
`default_nettype none

module store_merge
    import lsu_pkg::*;
(
    mem_lane_if.merge         lanes,
    input  wire logic         commit,
    input  wire align_t       alignment,
    input  wire access_size_e size,
    input  wire word_t        wdata
);

    lane_mask_t size_enable;
    lane_mask_t shifted_enable;
    word_t      shifted_data;

    always_comb begin
        case (size)
            SIZE_BYTE: size_enable = 4'b0001;
            SIZE_HALF: size_enable = 4'b0011;
            SIZE_WORD: size_enable = 4'b1111;
            default:   size_enable = 4'b0000;
        endcase
    end

    // Lanes past byte 3 fall off, the controller flags those as errors
    assign shifted_enable = size_enable << alignment;
    assign shifted_data   = wdata << {alignment, 3'b000};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (shifted_enable[i]) begin
                lanes.wr_byte[i] = shifted_data[i*8 +: 8];
            end else begin
                lanes.wr_byte[i] = lanes.rd_byte[i];  // Keep old byte
            end
        end
    end

    assign lanes.wr_en = commit ? shifted_enable : 4'b0000;

endmodule

`default_nettype wire

//--- apb_lsu_ctrl.sv
`default_nettype none

module apb_lsu_ctrl
    import lsu_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 10
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [15:0] paddr,
    output word_t            prdata,
    output logic             pready,
    output logic             pslverr,
    mem_lane_if.ctrl         lanes,
    output logic             commit,
    output align_t           alignment,
    output access_size_e     size,
    output logic             sign,
    input  wire word_t       load_data
);

    typedef enum logic {
        IDLE,
        ACCESS
    } state_t;

    state_t state;

    logic                        setup;
    logic [ADDR_FIELD_WIDTH-1:0] byte_addr;
    logic [MEM_ADDR_WIDTH-1:0]   mem_addr;
    access_size_e                size_code;
    align_t                      align_code;
    logic [1:0]                  last_offset;
    logic                        err_next;
    logic                        err_q;

    assign setup = (state == IDLE) && psel && !penable;

    // Address window decode
    assign byte_addr  = paddr[ADDR_FIELD_WIDTH-1:0];
    assign mem_addr   = byte_addr[MEM_ADDR_WIDTH-1:0];  // Upper bits ignored, memory wraps
    assign size_code  = access_size_e'(paddr[SIZE_LSB +: 2]);
    assign align_code = mem_addr[1:0];

    always_comb begin
        case (size_code)
            SIZE_BYTE: last_offset = 2'd0;
            SIZE_HALF: last_offset = 2'd1;
            default:   last_offset = 2'd3;
        endcase
    end

    // Bad size code or access reaching past byte 3
    assign err_next = (size_code == SIZE_BAD) ||
                      (({1'b0, align_code} + {1'b0, last_offset}) > 3'd3);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (setup) state <= ACCESS;
                default: state <= IDLE;  // No wait states
            endcase
        end
    end

    // Transfer attributes, stable through the access cycle
    always_ff @(posedge clk) begin
        if (setup) begin
            alignment <= align_code;
            size      <= size_code;
            sign      <= paddr[SIGN_BIT];
            err_q     <= err_next;
        end
    end

    assign lanes.rd_en      = setup;
    assign lanes.word_index = mem_addr[MEM_ADDR_WIDTH-1:2];

    assign pready  = (state == ACCESS) && psel && penable;
    assign pslverr = pready && err_q;
    assign commit  = pready && pwrite && !err_q;
    assign prdata  = (pready && !pwrite && !err_q) ? load_data : '0;

endmodule

`default_nettype wire

//--- apb_lsu_top.sv
`default_nettype none

module apb_lsu_top
    import lsu_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 10
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [15:0] paddr,
    input  wire word_t       pwdata,
    output word_t            prdata,
    output logic             pready,
    output logic             pslverr
);

    logic         commit;
    align_t       alignment;
    access_size_e size;
    logic         sign;
    word_t        load_data;

    mem_lane_if #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) lanes ();

    apb_lsu_ctrl #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) apb_lsu_ctrl_inst (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .lanes    (lanes.ctrl),
        .commit   (commit),
        .alignment(alignment),
        .size     (size),
        .sign     (sign),
        .load_data(load_data)
    );

    lane_memory #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) lane_memory_inst (
        .clk  (clk),
        .reset(reset),
        .lanes(lanes.mem)
    );

    load_align load_align_inst (
        .lanes    (lanes.load),
        .alignment(alignment),
        .size     (size),
        .sign     (sign),
        .load_data(load_data)
    );

    // Write data goes straight from the bus, it is stable in the access cycle
    store_merge store_merge_inst (
        .lanes    (lanes.merge),
        .commit   (commit),
        .alignment(alignment),
        .size     (size),
        .wdata    (pwdata)
    );

endmodule

`default_nettype wire

//--- apb_lsu_checker.sv
`default_nettype none

module apb_lsu_checker
    import lsu_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       psel,
    input wire logic       penable,
    input wire logic       pwrite,
    input wire logic       pready,
    input wire logic       pslverr,
    input wire logic       commit,
    input wire lane_mask_t wr_en
);

    timeunit 1ns;
    timeprecision 1ps;

    // Zero wait states, access always completes in its first cycle
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> pready)
        else $error("pready missing in the cycle after setup");

    assert property (@(posedge clk) disable iff (reset)
        pready |-> $past(psel && !penable))
        else $error("pready without a setup cycle before it");

    assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready)
        else $error("pslverr raised outside an access cycle");

    assert property (@(posedge clk) disable iff (reset)
        commit |-> (pready && pwrite))
        else $error("commit outside a write access");

    // Banks only change on a committed store
    assert property (@(posedge clk) disable iff (reset)
        (wr_en != 4'b0000) |-> commit)
        else $error("lane write enable without commit");

endmodule

bind apb_lsu_top apb_lsu_checker apb_lsu_checker_inst (
    .clk    (clk),
    .reset  (reset),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pready (pready),
    .pslverr(pslverr),
    .commit (commit),
    .wr_en  (lanes.wr_en)
);

`default_nettype wire

//--- tb_apb_lsu.sv
`default_nettype none

module tb_apb_lsu
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 20;  // Cycles allowed for pready

    // Bus sits in an access through reset, so only a reset FSM keeps pready low
    logic        clk     = 1'b0;
    logic        reset   = 1'b1;
    logic        psel    = 1'b1;
    logic        penable = 1'b1;
    logic        pwrite  = 1'b0;
    logic [15:0] paddr   = 16'h0000;
    word_t       pwdata  = 32'h0000_0000;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    byte_t       ref_mem [1024];  // Default memory of 1 KiB
    logic [15:0] lfsr_state = 16'd51;

    apb_lsu_top apb_lsu_top_inst (
        .clk    (clk),
        .reset  (reset),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("TEST FAILED");
        $fatal(1, reason);
    endtask

    // Steps x^16 + x^14 + x^13 + x^11 + 1 once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [15:0] make_paddr(input access_size_e size, input logic sign,
                                               input logic [11:0] addr);
        return {1'b0, sign, size, addr};
    endfunction

    function automatic logic access_error(input access_size_e size, input logic [1:0] offset);
        case (size)
            SIZE_BYTE: return 1'b0;
            SIZE_HALF: return offset == 2'd3;
            SIZE_WORD: return offset != 2'd0;
            default:   return 1'b1;
        endcase
    endfunction

    // Byte at addr is the least significant one
    function automatic word_t expected_load(input logic [9:0] addr, input access_size_e size,
                                            input logic sign);
        word_t value;
        value       = 32'd0;
        value[7:0]  = ref_mem[addr];
        if (size != SIZE_BYTE) begin
            value[15:8] = ref_mem[addr + 10'd1];
        end
        if (size == SIZE_WORD) begin
            value[23:16] = ref_mem[addr + 10'd2];
            value[31:24] = ref_mem[addr + 10'd3];
        end
        if (sign && size == SIZE_BYTE) begin
            value[31:8] = {24{value[7]}};
        end
        if (sign && size == SIZE_HALF) begin
            value[31:16] = {16{value[15]}};
        end
        return value;
    endfunction

    function automatic void model_store(input logic [9:0] addr, input access_size_e size,
                                        input word_t data);
        ref_mem[addr] = data[7:0];
        if (size != SIZE_BYTE) begin
            ref_mem[addr + 10'd1] = data[15:8];
        end
        if (size == SIZE_WORD) begin
            ref_mem[addr + 10'd2] = data[23:16];
            ref_mem[addr + 10'd3] = data[31:24];
        end
    endfunction

    // Setup then access with no idle cycle before the next transfer
    task automatic run_transfer(input logic write, input logic [15:0] addr, input word_t wdata,
                                output word_t rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            abort_run("pready never came during an access");
        end else begin
            assert (waited == 0) else begin
                $display("[FAIL] pready wait cycles at paddr %h: got %h expected %h",
                         addr, waited, 0);
                abort_run("wait states seen");
            end
            rdata = prdata;
            err   = pslverr;
        end
    endtask

    task automatic check_pslverr(input logic [15:0] addr, input logic err, input logic exp_err);
        assert (err === exp_err) else begin
            $display("[FAIL] pslverr at paddr %h: got %h expected %h", addr, err, exp_err);
            abort_run("pslverr mismatch");
        end
    endtask

    task automatic apb_write(input access_size_e size, input logic [11:0] addr,
                             input word_t data);
        logic [15:0] pa;
        logic        exp_err;
        word_t       rdata;
        logic        err;
        pa      = make_paddr(size, 1'b0, addr);
        exp_err = access_error(size, addr[1:0]);
        run_transfer(1'b1, pa, data, rdata, err);
        check_pslverr(pa, err, exp_err);
        if (!exp_err) begin
            model_store(addr[9:0], size, data);
        end
    endtask

    task automatic apb_read(input access_size_e size, input logic sign, input logic [11:0] addr);
        logic [15:0] pa;
        logic        exp_err;
        word_t       expected;
        word_t       rdata;
        logic        err;
        pa       = make_paddr(size, sign, addr);
        exp_err  = access_error(size, addr[1:0]);
        expected = exp_err ? 32'd0 : expected_load(addr[9:0], size, sign);
        run_transfer(1'b0, pa, 32'd0, rdata, err);
        check_pslverr(pa, err, exp_err);
        assert (rdata === expected) else begin
            $display("[FAIL] prdata at paddr %h: got %h expected %h", pa, rdata, expected);
            abort_run("prdata mismatch");
        end
    endtask

    task automatic bus_idle(input int cycles);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic fill_memory();
        logic [7:0] idx;
        for (int i = 0; i < 256; i++) begin
            idx = 8'(i);
            apb_write(SIZE_WORD, 12'(i * 4), {~idx, idx ^ 8'h3c, idx + 8'h81, idx});
        end
    endtask

    task automatic test_word_access();
        apb_write(SIZE_WORD, 12'h000, 32'hdead_beef);
        apb_write(SIZE_WORD, 12'h3fc, 32'h0123_4567);
        apb_write(SIZE_WORD, 12'h200, 32'h89ab_cdef);
        apb_read(SIZE_WORD, 1'b0, 12'h000);
        apb_read(SIZE_WORD, 1'b0, 12'h3fc);
        apb_read(SIZE_WORD, 1'b0, 12'h200);
        bus_idle(3);
        apb_read(SIZE_WORD, 1'b0, 12'h124);  // Untouched fill word
        apb_read(SIZE_WORD, 1'b0, 12'he00);  // Wraps onto 0x200
    endtask

    task automatic test_byte_lanes();
        apb_write(SIZE_WORD, 12'h040, 32'h1122_3344);
        for (int off = 0; off < 4; off++) begin
            apb_write(SIZE_BYTE, 12'h040 + 12'(off), 32'hffff_ffa0 + 32'(off));
            apb_read(SIZE_WORD, 1'b0, 12'h040);
            apb_read(SIZE_BYTE, 1'b0, 12'h040 + 12'(off));
        end
    endtask

    task automatic test_half_and_sign();
        apb_write(SIZE_HALF, 12'h080, 32'h1234_8a5c);
        apb_write(SIZE_HALF, 12'h082, 32'h0000_f731);
        apb_read(SIZE_HALF, 1'b0, 12'h080);
        apb_read(SIZE_HALF, 1'b1, 12'h080);
        apb_read(SIZE_HALF, 1'b0, 12'h082);
        apb_read(SIZE_HALF, 1'b1, 12'h082);
        apb_write(SIZE_BYTE, 12'h085, 32'h0000_00c3);
        apb_read(SIZE_BYTE, 1'b0, 12'h085);
        apb_read(SIZE_BYTE, 1'b1, 12'h085);
        apb_read(SIZE_HALF, 1'b1, 12'h084);
        apb_read(SIZE_WORD, 1'b1, 12'h080);
    endtask

    task automatic test_errors();
        apb_write(SIZE_WORD, 12'h0c0, 32'h5566_7788);
        apb_write(SIZE_HALF, 12'h0c3, 32'hffff_ffff);
        for (int off = 1; off < 4; off++) begin
            apb_write(SIZE_WORD, 12'h0c0 + 12'(off), 32'hffff_ffff);
            apb_read(SIZE_WORD, 1'b0, 12'h0c0 + 12'(off));
        end
        apb_write(SIZE_BAD, 12'h0c0, 32'hffff_ffff);
        apb_read(SIZE_HALF, 1'b1, 12'h0c3);
        apb_read(SIZE_BAD, 1'b0, 12'h0c0);
        apb_read(SIZE_WORD, 1'b0, 12'h0c0);  // Nothing may have changed
    endtask

    task automatic test_random();
        logic         write;
        access_size_e size;
        logic         sign;
        logic [11:0]  addr;
        word_t        data;
        for (int n = 0; n < 200; n++) begin
            write = 1'(random_bits(1));
            size  = access_size_e'(2'(random_bits(2)));
            sign  = 1'(random_bits(1));
            addr  = 12'(random_bits(12));
            data  = random_bits(32);
            if (write) begin
                apb_write(size, addr, data);
            end else begin
                apb_read(size, sign, addr);
            end
            if (random_bits(3) == 32'd0) begin
                bus_idle(1);
            end
        end
    endtask

    initial begin
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!pready && !pslverr) else begin
            $display("[FAIL] pready/pslverr after reset: got %h/%h expected 0/0",
                     pready, pslverr);
            abort_run("bus outputs active after reset");
        end
        fill_memory();
        test_word_access();
        test_byte_lanes();
        bus_idle(2);
        test_half_and_sign();
        test_errors();
        test_random();
        bus_idle(2);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
lsu_pkg.sv
mem_lane_if.sv
byte_bank.sv
lane_memory.sv
load_align.sv
store_merge.sv
apb_lsu_ctrl.sv
apb_lsu_top.sv
apb_lsu_checker.sv
tb_apb_lsu.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_apb_lsu
FILELIST := all.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
